// ==== run_sim.sh ====
#!/bin/sh
# Build the LED self-test testbench with Verilator, run it and
# decide pass or fail from the simulation log.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --timescale 1ns/10ps \
	-f tb.f --top-module tb_led_tester \
	-Mdir "$BUILD_DIR" -o sim_led_tester; then
	echo "verilator build failed"
	exit 1
fi

"$BUILD_DIR/sim_led_tester" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi

// ==== src/btn_sync.sv ====
// two-stage synchroniser for the push button vector
// keeps metastable button edges away from the board LED drivers
// a button value shows up on btn_out two clocks after it is sampled

`timescale 1ns/10ps
`default_nettype none

module btn_sync
	import led_test_pkg::*;
(
	input  logic     slow_clk,
	input  logic     rst,
	input  btn_vec_t btn_raw,
	output btn_vec_t btn_out
);

	// first stage may go metastable, never read it elsewhere
	btn_vec_t btn_meta;

	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst) begin
			btn_meta <= '0;
			btn_out <= '0;
		end else begin
			btn_meta <= btn_raw;
			// second stage has had a full clock to settle
			btn_out <= btn_meta;
		end
	end

endmodule

`default_nettype wire

// ==== src/key_debounce.sv ====
// debouncer for one active-low key
// the pin is brought in through a two flip-flop synchroniser, then a
// counter checks that the new value is seen on DEBOUNCE_CYCLES
// consecutive clocks before the debounced level follows it
// pressed is the clean level, press a one-cycle strobe on each new press
// from the first edge that samples the new pin value, the level and the
// strobe's effect land DEBOUNCE_CYCLES+1 edges later

`timescale 1ns/10ps
`default_nettype none

module key_debounce
	import led_test_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = 16
) (
	input  logic slow_clk,
	input  logic rst,
	input  logic key_n,
	output logic pressed,
	output logic press
);

	// synchroniser stages, raw pin polarity so reset means released
	logic key_meta;
	logic key_sync;
	// synchronised key in pressed polarity
	logic key_down;
	// cycles the synchronised key has disagreed with the level
	cycle_cnt_t stable_cnt;
	logic level;
	logic differs;
	logic hit;

	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst) begin
			key_meta <= 1'b1;
			key_sync <= 1'b1;
		end else begin
			key_meta <= key_n;
			key_sync <= key_meta;
		end
	end

	assign key_down = ~key_sync;
	assign differs = (key_down != level);

	// this cycle is the DEBOUNCE_CYCLES-th one in a row with a new value
	assign hit = differs && (stable_cnt == cycle_cnt_t'(DEBOUNCE_CYCLES - 1));

	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst) begin
			stable_cnt <= '0;
			level <= 1'b0;
		end else if (!differs) begin
			// agreement again, any glitch so far is forgotten
			stable_cnt <= '0;
		end else if (hit) begin
			level <= key_down;
			stable_cnt <= '0;
		end else begin
			stable_cnt <= stable_cnt + 1'b1;
		end
	end

	assign pressed = level;

	// strobe sits in the cycle before the level commits
	// only a change towards pressed makes one, releases stay silent
	assign press = hit && key_down;

endmodule

`default_nettype wire

// ==== src/led_scanner.sv ====
// bouncing single-LED scanner for the green LED bar
// one lit bit walks up to the top of the bar and back down to bit 0,
// one position per step tick, period 2*(NUM_LEDS-1) ticks
// pause_press toggles the pause flag, reverse_press flips the direction
// both strobes act on the edge where they are high
// NUM_LEDS must be at least 3

`timescale 1ns/10ps
`default_nettype none

module led_scanner
	import led_test_pkg::*;
#(
	parameter int NUM_LEDS = 8
) (
	input  logic                slow_clk,
	input  logic                rst,
	input  logic                step,
	input  logic                pause_press,
	input  logic                reverse_press,
	output logic [NUM_LEDS-1:0] bar,
	output scan_dir_t           dir,
	output logic                paused
);

	logic [NUM_LEDS-1:0] bar_next;
	// direction after a reverse request and the end rule
	scan_dir_t dir_turned;
	scan_dir_t dir_next;
	logic move;

	function automatic scan_dir_t flip_dir(input scan_dir_t d);
		return (d == DIR_UP) ? DIR_DOWN : DIR_UP;
	endfunction

	// at either end the direction always points back into the bar
	function automatic scan_dir_t end_rule(input logic [NUM_LEDS-1:0] pos,
			input scan_dir_t d);
		scan_dir_t r;
		r = d;
		if (pos[NUM_LEDS-1] && d == DIR_UP)
			r = DIR_DOWN;
		else if (pos[0] && d == DIR_DOWN)
			r = DIR_UP;
		return r;
	endfunction

	// pause is judged on the flag as it stands before this edge
	assign move = step && !paused;

	always_comb begin
		// reverse first, then the end rule, so a flip at an end is undone
		dir_turned = end_rule(bar, reverse_press ? flip_dir(dir) : dir);
		bar_next = bar;
		dir_next = dir_turned;
		if (move) begin
			if (dir_turned == DIR_UP)
				bar_next = bar << 1;
			else
				bar_next = bar >> 1;
			// turn around as soon as the lit bit lands on an end
			dir_next = end_rule(bar_next, dir_turned);
		end
	end

	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst) begin
			// LED 0 lit, heading up
			bar <= {{(NUM_LEDS - 1){1'b0}}, 1'b1};
			dir <= DIR_UP;
			paused <= 1'b0;
		end else begin
			bar <= bar_next;
			dir <= dir_next;
			paused <= paused ^ pause_press;
		end
	end

endmodule

`default_nettype wire

// ==== src/led_test_pkg.sv ====
// shared types for the board LED self-test panel
// holds the pin vector widths, the counter width used for the debounce
// and step timers, and the direction encoding of the scanner FSM
// every design file picks these up with a wildcard import in its header

`default_nettype none

package led_test_pkg;

	// raw key pins, active low
	// bit 0 pauses and resumes the scanner, bit 1 reverses it
	typedef logic [1:0] key_vec_t;

	// push buttons, mirrored straight onto the first board LEDs
	typedef logic [3:0] btn_vec_t;

	// board status LEDs
	// [3:0] buttons, [4] scan direction is up, [5] scanner paused
	typedef logic [5:0] board_led_t;

	// width of the debounce and step counters
	// 24 bits covers up to about 16.7M cycles, enough for a
	// quarter second step at a 27 MHz slow_clk
	typedef logic [23:0] cycle_cnt_t;

	// direction FSM of the bouncing scanner
	// DIR_UP walks towards the top bit, DIR_DOWN back to bit 0
	typedef enum logic {
		DIR_UP   = 1'b0,
		DIR_DOWN = 1'b1
	} scan_dir_t;

endpackage

`default_nettype wire

// ==== src/led_test_top.sv ====
// top level of the board LED self-test panel
// key 0 pauses and resumes the bouncing scanner on ledg, key 1 reverses it
// the four buttons are mirrored on led[3:0], led[4] is high while the scan
// heads up and led[5] is high while the scan is paused
// everything runs on slow_clk, the step tick is only a clock enable
// defaults assume slow_clk at 27 MHz, 10 ms debounce and 4 steps a second

`timescale 1ns/10ps
`default_nettype none

module led_test_top
	import led_test_pkg::*;
#(
	parameter int NUM_LEDS        = 8,
	parameter int DEBOUNCE_CYCLES = 270_000,
	parameter int STEP_CYCLES     = 6_750_000
) (
	input  logic                slow_clk,
	input  logic                rst,
	input  key_vec_t            key,
	input  btn_vec_t            btn,
	output board_led_t          led,
	output logic [NUM_LEDS-1:0] ledg
);

	logic pause_press;
	logic reverse_press;
	logic step;
	logic paused;
	scan_dir_t dir;
	btn_vec_t btn_s;
	logic [NUM_LEDS-1:0] bar;

	// pause key, only the press strobe is needed here
	key_debounce #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_key_pause (
		.slow_clk(slow_clk),
		.rst     (rst),
		.key_n   (key[0]),
		.pressed (),
		.press   (pause_press)
	);

	// reverse key
	key_debounce #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_key_reverse (
		.slow_clk(slow_clk),
		.rst     (rst),
		.key_n   (key[1]),
		.pressed (),
		.press   (reverse_press)
	);

	btn_sync u_btn_sync (
		.slow_clk(slow_clk),
		.rst     (rst),
		.btn_raw (btn),
		.btn_out (btn_s)
	);

	step_timer #(
		.STEP_CYCLES(STEP_CYCLES)
	) u_step_timer (
		.slow_clk(slow_clk),
		.rst     (rst),
		.step    (step)
	);

	led_scanner #(
		.NUM_LEDS(NUM_LEDS)
	) u_scanner (
		.slow_clk     (slow_clk),
		.rst          (rst),
		.step         (step),
		.pause_press  (pause_press),
		.reverse_press(reverse_press),
		.bar          (bar),
		.dir          (dir),
		.paused       (paused)
	);

	assign ledg = bar;

	// status LEDs, buttons in the low nibble
	assign led = {paused, (dir == DIR_UP), btn_s};

endmodule

`default_nettype wire

// ==== src/step_timer.sv ====
// step tick generator for the LED scanner
// a free-running counter wraps every STEP_CYCLES clocks and raises step
// for one cycle after each wrap
// step is a clock enable, the scanner stays in the slow_clk domain
// first tick is high in cycle STEP_CYCLES after reset release

`timescale 1ns/10ps
`default_nettype none

module step_timer
	import led_test_pkg::*;
#(
	parameter int STEP_CYCLES = 4
) (
	input  logic slow_clk,
	input  logic rst,
	output logic step
);

	cycle_cnt_t cycle_cnt;
	logic wrap;

	// last count of the period
	assign wrap = (cycle_cnt == cycle_cnt_t'(STEP_CYCLES - 1));

	always_ff @(posedge slow_clk, posedge rst) begin
		if (rst) begin
			cycle_cnt <= '0;
			step <= 1'b0;
		end else begin
			if (wrap)
				cycle_cnt <= '0;
			else
				cycle_cnt <= cycle_cnt + 1'b1;
			// registered so the tick is glitch free and low in reset
			step <= wrap;
		end
	end

endmodule

`default_nettype wire

// ==== tb.f ====
src/led_test_pkg.sv
src/key_debounce.sv
src/btn_sync.sv
src/step_timer.sv
src/led_scanner.sv
src/led_test_top.sv
verification/tb_led_tester.sv

// ==== verification/tb_led_tester.sv ====
// directed testbench for the board LED self-test panel
// drives keys and buttons on led_test_top with short debounce and step
// periods, and follows the scanner with a position model
// ledg and the status LEDs are compared with the model on every cycle
// run through tb.f, the pass or fail verdict is the last line printed

`timescale 1ns/10ps
`default_nettype none

module tb_led_tester
	import led_test_pkg::*;
;

	localparam int NUM_LEDS = 8;
	localparam int DEBOUNCE_CYCLES = 8;
	localparam int STEP_CYCLES = 4;
	// the tests need well under 1500 cycles, this leaves wide margin
	localparam int TIMEOUT_CYCLES = 4000;

	logic slow_clk;
	logic rst;
	key_vec_t key;
	btn_vec_t btn;
	board_led_t led;
	logic [NUM_LEDS-1:0] ledg;

	int seed = 32'hba3e_bcc2;
	int check_count = 0;
	int error_count = 0;
	int cycle_count = 0;

	// reference model of the scanner
	// cyc counts edges since reset release, m_pos is the lit bit
	int cyc = 0;
	int m_pos = 0;
	bit m_up = 1'b1;
	bit m_paused = 1'b0;
	bit model_move;
	// edges on which a debounced key press takes effect, -1 when none
	int pause_edge = -1;
	int rev_edge = -1;

	led_test_top #(
		.NUM_LEDS       (NUM_LEDS),
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
		.STEP_CYCLES    (STEP_CYCLES)
	) DUT (
		.slow_clk(slow_clk),
		.rst     (rst),
		.key     (key),
		.btn     (btn),
		.led     (led),
		.ledg    (ledg)
	);

	initial begin
		slow_clk = 1'b0;
		forever #50 slow_clk = ~slow_clk;
	end

	always @(posedge slow_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles",
				TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// model update, inputs only change 10 ns after the edge
	always @(posedge slow_clk) begin
		if (rst) begin
			cyc = 0;
			m_pos = 0;
			m_up = 1'b1;
			m_paused = 1'b0;
		end else begin
			cyc = cyc + 1;
			// the tick is registered, the bar moves one edge after each period ends
			model_move = (cyc > STEP_CYCLES) && ((cyc - 1) % STEP_CYCLES == 0)
				&& !m_paused;
			if (cyc == rev_edge)
				m_up = !m_up;
			// the end rule wins over a reverse at either end
			if (m_pos == NUM_LEDS - 1)
				m_up = 1'b0;
			else if (m_pos == 0)
				m_up = 1'b1;
			if (model_move) begin
				if (m_up)
					m_pos = m_pos + 1;
				else
					m_pos = m_pos - 1;
				if (m_pos == NUM_LEDS - 1)
					m_up = 1'b0;
				else if (m_pos == 0)
					m_up = 1'b1;
			end
			// pause judged on the flag before this edge
			if (cyc == pause_edge)
				m_paused = !m_paused;
		end
	end

	task automatic compare_values(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count = check_count + 1;
		if (actual !== expected) begin
			error_count = error_count + 1;
			$display("ERR %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// step to 10 ns after the next rising edge, where inputs are driven
	task automatic next_cycle;
		@(posedge slow_clk);
		#10;
	endtask

	// ledg, direction and pause LEDs against the model
	task automatic compare_scan(input string name);
		logic [NUM_LEDS-1:0] exp_bar;
		exp_bar = '0;
		exp_bar[m_pos] = 1'b1;
		compare_values({name, " ledg"}, 32'(exp_bar), 32'(ledg));
		compare_values({name, " dir led"}, 32'(m_up), 32'(led[4]));
		compare_values({name, " pause led"}, 32'(m_paused), 32'(led[5]));
	endtask

	task automatic run_cycles(input int n, input string name);
		repeat (n) begin
			next_cycle;
			compare_scan(name);
		end
	endtask

	// lands on the first cycle the model reaches pos heading in dir up
	task automatic wait_for_position(input int pos, input bit up, input string name);
		while (m_pos == pos && m_up == up)
			run_cycles(1, name);
		do begin
			run_cycles(1, name);
		end while (!(m_pos == pos && m_up == up));
	endtask

	task automatic test_reset;
		compare_values("reset ledg", 32'd1, 32'(ledg));
		compare_values("reset dir led", 32'd1, 32'(led[4]));
		compare_values("reset pause led", 32'd0, 32'(led[5]));
		compare_values("reset buttons", 32'd0, 32'(led[3:0]));
	endtask

	// three full bounce periods, counting arrivals at both ends
	task automatic test_bounce;
		logic [NUM_LEDS-1:0] prev_bar;
		logic [NUM_LEDS-1:0] top_bar;
		logic [NUM_LEDS-1:0] bottom_bar;
		int top_hits;
		int bottom_hits;
		top_bar = '0;
		top_bar[NUM_LEDS-1] = 1'b1;
		bottom_bar = '0;
		bottom_bar[0] = 1'b1;
		top_hits = 0;
		bottom_hits = 0;
		prev_bar = ledg;
		repeat (3 * 2 * (NUM_LEDS - 1) * STEP_CYCLES + STEP_CYCLES) begin
			run_cycles(1, "bounce");
			if (ledg == top_bar && prev_bar != top_bar)
				top_hits = top_hits + 1;
			if (ledg == bottom_bar && prev_bar != bottom_bar)
				bottom_hits = bottom_hits + 1;
			prev_bar = ledg;
		end
		compare_values("bounce top turns", 32'd3, 32'(top_hits));
		compare_values("bounce bottom turns", 32'd3, 32'(bottom_hits));
	endtask

	// two register stages between btn and led[3:0]
	task automatic test_buttons;
		btn_vec_t value;
		btn_vec_t prev;
		prev = btn;
		repeat (10) begin
			value = btn_vec_t'($random(seed));
			btn = value;
			run_cycles(1, "buttons");
			compare_values("buttons one clock", 32'(prev), 32'(led[3:0]));
			run_cycles(1, "buttons");
			compare_values("buttons two clocks", 32'(value), 32'(led[3:0]));
			prev = value;
		end
	endtask

	task automatic test_debounce;
		logic [NUM_LEDS-1:0] held_bar;
		// one cycle too short to commit
		key[0] = 1'b0;
		run_cycles(DEBOUNCE_CYCLES - 1, "glitch");
		key[0] = 1'b1;
		run_cycles(DEBOUNCE_CYCLES + 4, "glitch");
		compare_values("glitch ignored", 32'd0, 32'(led[5]));

		// pin first sampled one edge after the drive, then D+1 edges to commit
		key[0] = 1'b0;
		pause_edge = cyc + DEBOUNCE_CYCLES + 2;
		run_cycles(DEBOUNCE_CYCLES + 1, "pause press");
		compare_values("pause not yet", 32'd0, 32'(led[5]));
		run_cycles(1, "pause press");
		compare_values("pause set", 32'd1, 32'(led[5]));
		held_bar = ledg;
		key[0] = 1'b1;
		run_cycles(DEBOUNCE_CYCLES + 4, "paused");
		run_cycles(3 * STEP_CYCLES, "paused");
		compare_values("scan held", 32'(held_bar), 32'(ledg));

		// second press resumes from the held position
		key[0] = 1'b0;
		pause_edge = cyc + DEBOUNCE_CYCLES + 2;
		run_cycles(DEBOUNCE_CYCLES + 2, "resume press");
		compare_values("pause cleared", 32'd0, 32'(led[5]));
		compare_values("resume position", 32'(held_bar), 32'(ledg));
		key[0] = 1'b1;
		run_cycles(DEBOUNCE_CYCLES + 4, "resumed");
		compare_values("scan resumed", 32'd1, 32'(ledg != held_bar));
	endtask

	task automatic test_reverse;
		logic [NUM_LEDS-1:0] flip_bar;
		logic [NUM_LEDS-1:0] top_bar;
		top_bar = '0;
		top_bar[NUM_LEDS-1] = 1'b1;

		// mid-bar, the press lands two steps later on bit 4
		wait_for_position(2, 1'b1, "reverse mid wait");
		key[1] = 1'b0;
		rev_edge = cyc + DEBOUNCE_CYCLES + 2;
		run_cycles(DEBOUNCE_CYCLES + 1, "reverse mid");
		compare_values("reverse mid before", 32'd1, 32'(led[4]));
		run_cycles(1, "reverse mid");
		compare_values("reverse mid flipped", 32'd0, 32'(led[4]));
		flip_bar = ledg;
		key[1] = 1'b1;
		run_cycles(DEBOUNCE_CYCLES + 4, "reverse mid");
		compare_values("reverse mid heads down", 32'd1, 32'(ledg < flip_bar));

		// press lands while the top bit is lit, the end rule keeps it heading down
		wait_for_position(NUM_LEDS - 3, 1'b1, "reverse end wait");
		key[1] = 1'b0;
		rev_edge = cyc + DEBOUNCE_CYCLES + 2;
		run_cycles(DEBOUNCE_CYCLES + 2, "reverse end");
		compare_values("reverse end position", 32'(top_bar), 32'(ledg));
		compare_values("reverse end dir", 32'd0, 32'(led[4]));
		key[1] = 1'b1;
		run_cycles(DEBOUNCE_CYCLES + 4, "reverse end");
		compare_values("reverse end heads down", 32'd1, 32'(ledg < top_bar));
	endtask

	initial begin
		key = 2'b11;
		// buttons held down through reset, the mirror must still read zero
		btn = 4'hf;
		rst = 1'b1;
		repeat (8) @(posedge slow_clk);
		#10;
		rst = 1'b0;
		test_reset;
		test_bounce;
		test_buttons;
		test_debounce;
		test_reverse;
		$display("checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
